// File: Bender.yml
package:
  name: exec_subsystem

sources:
  - files:
      - src/exec_pkg.sv
      - src/exec_alu.sv
      - src/load_scoreboard.sv
      - src/exec_unit.sv
      - src/mem_access_unit.sv
      - src/exec_subsystem.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/exec_subsystem_props.sv
      - test/exec_subsystem_tb.sv

// File: exec_subsystem.f
src/exec_pkg.sv
src/exec_alu.sv
src/load_scoreboard.sv
src/exec_unit.sv
src/mem_access_unit.sv
src/exec_subsystem.sv
test/clock_gen.sv
test/exec_subsystem_props.sv
test/exec_subsystem_tb.sv

// File: src/exec_alu.sv
module exec_alu import exec_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_fn_t         fn,
    output logic [xlen-1:0] result
);

    logic [shamt_width-1:0] shamt;
    logic                   less_signed;
    logic                   less_unsigned;

    // only the low bits of b count for shifts
    assign shamt = b[shamt_width-1:0];

    assign less_signed   = $signed(a) < $signed(b);
    assign less_unsigned = a < b;

    always_comb begin
        case (fn)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                result = $signed(a) >>> shamt;
            end
            // compare result sits in bit 0
            alu_slt: begin
                result = {{(xlen - 1){1'b0}}, less_signed};
            end
            alu_sltu: begin
                result = {{(xlen - 1){1'b0}}, less_unsigned};
            end
            default: begin
                result = a + b;
            end
        endcase
    end

endmodule

// File: src/exec_pkg.sv
package exec_pkg;

    // --------------------
    // datapath sizes
    // --------------------
    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count = 1 << reg_addr_width;
    localparam int shamt_width = $clog2(xlen);

    // data memory, word addressed through bits 7:2
    localparam int mem_words = 64;
    localparam int mem_index_width = $clog2(mem_words);
    localparam int mem_latency = 2;
    localparam int mem_count_width = $clog2(mem_latency + 1);

    // --------------------
    // encodings
    // --------------------

    // decoded operation from the issue stage
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9,
        op_lw   = 4'd10,
        op_sw   = 4'd11,
        op_jal  = 4'd12,
        op_beq  = 4'd13,
        op_bne  = 4'd14
    } exec_op_t;

    // first-pass operand pair
    typedef enum logic [1:0] {
        sel_imm_zero = 2'd0,
        sel_rs1_rs2  = 2'd1,
        sel_pc_imm   = 2'd2,
        sel_rs1_imm  = 2'd3
    } operand_sel_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_fn_t;

endpackage

// File: src/exec_subsystem.sv
module exec_subsystem import exec_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      issue_valid,
    output logic                      issue_ready,
    input  exec_op_t                  op,
    input  operand_sel_t              sel,
    input  logic [reg_addr_width-1:0] rd_addr,
    input  logic [reg_addr_width-1:0] rs1_addr,
    input  logic [reg_addr_width-1:0] rs2_addr,
    input  logic [xlen-1:0]           pc,
    input  logic [xlen-1:0]           imm,
    input  logic [xlen-1:0]           rs1_value,
    input  logic [xlen-1:0]           rs2_value,
    output logic                      commit_valid,
    output logic [reg_addr_width-1:0] commit_rd,
    output logic [xlen-1:0]           commit_value,
    output logic                      commit_write,
    output logic                      redirect_valid,
    output logic [xlen-1:0]           redirect_pc
);

    logic                      hazard;
    logic                      load_issue;
    logic [reg_addr_width-1:0] load_rd;
    logic                      load_done;
    logic [reg_addr_width-1:0] load_done_rd;
    logic                      exu_valid;
    logic                      exu_ready;
    exec_op_t                  exu_op;
    logic [reg_addr_width-1:0] exu_rd;
    logic [xlen-1:0]           exu_result;
    logic [xlen-1:0]           exu_store_data;

    exec_unit exec_unit_i (
        .clock          (clock),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .op             (op),
        .sel            (sel),
        .rd_addr        (rd_addr),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .pc             (pc),
        .imm            (imm),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .hazard         (hazard),
        .load_issue     (load_issue),
        .load_rd        (load_rd),
        .exu_valid      (exu_valid),
        .exu_op         (exu_op),
        .exu_rd         (exu_rd),
        .exu_result     (exu_result),
        .exu_store_data (exu_store_data),
        .exu_ready      (exu_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    load_scoreboard load_scoreboard_i (
        .clock        (clock),
        .reset        (reset),
        .load_issue   (load_issue),
        .load_rd      (load_rd),
        .load_done    (load_done),
        .load_done_rd (load_done_rd),
        .rd_addr      (rd_addr),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .hazard       (hazard)
    );

    mem_access_unit mem_access_unit_i (
        .clock          (clock),
        .reset          (reset),
        .exu_valid      (exu_valid),
        .exu_ready      (exu_ready),
        .exu_op         (exu_op),
        .exu_rd         (exu_rd),
        .exu_result     (exu_result),
        .exu_store_data (exu_store_data),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .commit_write   (commit_write),
        .load_done      (load_done),
        .load_done_rd   (load_done_rd)
    );

endmodule

// File: src/exec_unit.sv
module exec_unit import exec_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      issue_valid,
    output logic                      issue_ready,
    input  exec_op_t                  op,
    input  operand_sel_t              sel,
    input  logic [reg_addr_width-1:0] rd_addr,
    input  logic [reg_addr_width-1:0] rs1_addr,
    input  logic [reg_addr_width-1:0] rs2_addr,
    input  logic [xlen-1:0]           pc,
    input  logic [xlen-1:0]           imm,
    input  logic [xlen-1:0]           rs1_value,
    input  logic [xlen-1:0]           rs2_value,
    input  logic                      hazard,
    output logic                      load_issue,
    output logic [reg_addr_width-1:0] load_rd,
    output logic                      exu_valid,
    output exec_op_t                  exu_op,
    output logic [reg_addr_width-1:0] exu_rd,
    output logic [xlen-1:0]           exu_result,
    output logic [xlen-1:0]           exu_store_data,
    input  logic                      exu_ready,
    output logic                      redirect_valid,
    output logic [xlen-1:0]           redirect_pc
);

    logic            pass1_q;
    logic            pass2_q;
    logic            busy;
    logic            accept;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] imm_q;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] result_q;
    logic            taken_q;
    logic            is_branch;
    alu_fn_t         alu_fn;

    // first-pass function per operation
    function automatic alu_fn_t first_fn(exec_op_t o);
        case (o)
            op_sub, op_beq, op_bne: return alu_sub;
            op_and: return alu_and;
            op_or: return alu_or;
            op_xor: return alu_xor;
            op_sll: return alu_sll;
            op_srl: return alu_srl;
            op_sra: return alu_sra;
            op_slt: return alu_slt;
            op_sltu: return alu_sltu;
            default: return alu_add;
        endcase
    endfunction

    // --------------------
    // issue handshake
    // --------------------
    assign busy        = pass1_q | pass2_q | exu_valid;
    assign issue_ready = ~busy & ~hazard;
    assign accept      = issue_valid & issue_ready;

    assign load_issue = accept & (op == op_lw);
    assign load_rd    = rd_addr;

    assign is_branch = (exu_op == op_beq) || (exu_op == op_bne);

    // second pass is always an add
    assign alu_fn = pass1_q ? first_fn(exu_op) : alu_add;

    exec_alu exec_alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .fn     (alu_fn),
        .result (alu_y)
    );

    // --------------------
    // sequencing
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            pass1_q        <= 1'b0;
            pass2_q        <= 1'b0;
            exu_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            pass1_q        <= accept;
            pass2_q        <= pass1_q;
            redirect_valid <= pass2_q & taken_q;
            if (pass2_q) begin
                exu_valid <= 1'b1;
            end else if (exu_valid && exu_ready) begin
                exu_valid <= 1'b0;
            end
        end
    end

    // operands and results
    always_ff @(posedge clock) begin
        if (accept) begin
            exu_op         <= op;
            exu_rd         <= rd_addr;
            exu_store_data <= rs2_value;
            pc_q           <= pc;
            imm_q          <= imm;
            case (sel)
                sel_imm_zero: begin
                    alu_a <= imm;
                    alu_b <= '0;
                end
                sel_rs1_rs2: begin
                    alu_a <= rs1_value;
                    alu_b <= rs2_value;
                end
                sel_pc_imm: begin
                    alu_a <= pc;
                    alu_b <= imm;
                end
                default: begin
                    alu_a <= rs1_value;
                    alu_b <= imm;
                end
            endcase
        end else if (pass1_q) begin
            // jal target came out of pass 1, branch compare too
            result_q <= alu_y;
            case (exu_op)
                op_jal: taken_q <= 1'b1;
                op_beq: taken_q <= (alu_y == '0);
                op_bne: taken_q <= (alu_y != '0);
                default: taken_q <= 1'b0;
            endcase
            alu_a <= pc_q;
            alu_b <= is_branch ? imm_q : xlen'(4);
        end
        if (pass2_q) begin
            exu_result  <= (exu_op == op_jal) ? alu_y : result_q;
            redirect_pc <= (exu_op == op_jal) ? result_q : alu_y;
        end
    end

endmodule

// File: src/load_scoreboard.sv
module load_scoreboard import exec_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      load_issue,
    input  logic [reg_addr_width-1:0] load_rd,
    input  logic                      load_done,
    input  logic [reg_addr_width-1:0] load_done_rd,
    input  logic [reg_addr_width-1:0] rd_addr,
    input  logic [reg_addr_width-1:0] rs1_addr,
    input  logic [reg_addr_width-1:0] rs2_addr,
    output logic                      hazard
);

    // x0 has no lock bit
    logic [reg_count-1:1] lock_q;
    logic [reg_count-1:0] lock_vec;
    logic [reg_count-1:0] set_mask;
    logic [reg_count-1:0] clear_mask;

    assign set_mask   = load_issue ? (reg_count'(1) << load_rd) : '0;
    assign clear_mask = load_done ? (reg_count'(1) << load_done_rd) : '0;

    // set wins, same register cannot be issued while still locked
    always_ff @(posedge clock) begin
        if (reset) begin
            lock_q <= '0;
        end else begin
            lock_q <= (lock_q & ~clear_mask[reg_count-1:1]) | set_mask[reg_count-1:1];
        end
    end

    assign lock_vec = {lock_q, 1'b0};

    // raw and waw against any load still in flight
    assign hazard = lock_vec[rd_addr] | lock_vec[rs1_addr] | lock_vec[rs2_addr];

endmodule

// File: src/mem_access_unit.sv
module mem_access_unit import exec_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      exu_valid,
    output logic                      exu_ready,
    input  exec_op_t                  exu_op,
    input  logic [reg_addr_width-1:0] exu_rd,
    input  logic [xlen-1:0]           exu_result,
    input  logic [xlen-1:0]           exu_store_data,
    output logic                      commit_valid,
    output logic [reg_addr_width-1:0] commit_rd,
    output logic [xlen-1:0]           commit_value,
    output logic                      commit_write,
    output logic                      load_done,
    output logic [reg_addr_width-1:0] load_done_rd
);

    logic [xlen-1:0]            mem [mem_words];
    logic                       active;
    logic [mem_count_width-1:0] count;
    exec_op_t                   op_q;
    logic [reg_addr_width-1:0]  rd_q;
    logic [xlen-1:0]            addr_q;
    logic [xlen-1:0]            data_q;
    logic [mem_index_width-1:0] mem_index;
    logic                       take;
    logic                       take_mem;
    logic                       finish;

    function automatic logic writes_rd(exec_op_t o, logic [reg_addr_width-1:0] r);
        return (r != '0) && !(o inside {op_beq, op_bne, op_sw});
    endfunction

    assign exu_ready = ~active;
    assign take      = exu_valid & exu_ready;
    assign take_mem  = (exu_op == op_lw) || (exu_op == op_sw);
    assign finish    = active && (count == mem_count_width'(1));
    assign mem_index = addr_q[mem_index_width + 1:2];

    assign load_done_rd = commit_rd;

    // --------------------
    // access timing
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            active       <= 1'b0;
            count        <= '0;
            commit_valid <= 1'b0;
            load_done    <= 1'b0;
        end else begin
            commit_valid <= (take && !take_mem) || finish;
            load_done    <= finish && (op_q == op_lw);
            if (take && take_mem) begin
                active <= 1'b1;
                count  <= mem_count_width'(mem_latency);
            end else if (finish) begin
                active <= 1'b0;
            end else if (active) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (finish && (op_q == op_sw)) begin
            mem[mem_index] <= data_q;
        end
    end

    // alu results pass straight to commit
    always_ff @(posedge clock) begin
        if (take) begin
            op_q         <= exu_op;
            rd_q         <= exu_rd;
            addr_q       <= exu_result;
            data_q       <= exu_store_data;
            commit_rd    <= exu_rd;
            commit_value <= exu_result;
            commit_write <= writes_rd(exu_op, exu_rd);
        end else if (finish) begin
            commit_rd    <= rd_q;
            commit_value <= (op_q == op_lw) ? mem[mem_index] : data_q;
            commit_write <= writes_rd(op_q, rd_q);
        end
    end

endmodule

// File: test/clock_gen.sv
module clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // reset held for ten rising edges
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// File: test/exec_subsystem_props.sv
module exec_subsystem_props import exec_pkg::*; (
    input logic                      clock,
    input logic                      reset,
    input logic                      issue_valid,
    input logic                      issue_ready,
    input logic                      exu_valid,
    input logic                      exu_ready,
    input exec_op_t                  exu_op,
    input logic [reg_addr_width-1:0] exu_rd,
    input logic [xlen-1:0]           exu_result,
    input logic [xlen-1:0]           exu_store_data,
    input logic                      redirect_valid
);

    int failures;

    initial failures = 0;

    // issue stays blocked through both passes until the result is held
    accept_blocks_issue: assert property (
        @(posedge clock) disable iff (reset)
        issue_valid && issue_ready |=> !issue_ready ##1 !issue_ready
            ##1 (exu_valid && !issue_ready)
    ) else begin
        $error("issue not held off through both passes, or result not held on time");
        failures++;
    end

    redirect_single_cycle: assert property (
        @(posedge clock) disable iff (reset) redirect_valid |=> !redirect_valid
    ) else begin
        $error("redirect_valid high for more than one cycle");
        failures++;
    end

    // --------------------
    // exu handshake
    // --------------------
    exu_held_stable: assert property (
        @(posedge clock) disable iff (reset)
        exu_valid && !exu_ready |=> exu_valid && $stable(exu_op) && $stable(exu_rd)
            && $stable(exu_result) && $stable(exu_store_data)
    ) else begin
        $error("exu payload changed or dropped before exu_ready");
        failures++;
    end

endmodule

bind exec_unit exec_subsystem_props exec_subsystem_props_i (
    .clock          (clock),
    .reset          (reset),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .exu_valid      (exu_valid),
    .exu_ready      (exu_ready),
    .exu_op         (exu_op),
    .exu_rd         (exu_rd),
    .exu_result     (exu_result),
    .exu_store_data (exu_store_data),
    .redirect_valid (redirect_valid)
);

// File: test/exec_subsystem_tb.sv
module exec_subsystem_tb import exec_pkg::*; ();

    typedef struct packed {
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           value;
        logic                      write;
        logic                      redir;
        logic [xlen-1:0]           target;
    } expect_t;

    localparam int alu_count    = 40;
    localparam int branch_count = 16;
    localparam int mem_rounds   = 8;
    localparam int dep_rounds   = 4;
    localparam int burst_count  = 10;
    localparam int total_instr  = alu_count + branch_count + 3 * mem_rounds
                                  + 3 * dep_rounds + 1 + burst_count;
    localparam int timeout_cycles = 40 * total_instr + 1000;

    logic                      clock;
    logic                      reset;
    logic                      issue_valid;
    logic                      issue_ready;
    exec_op_t                  op;
    operand_sel_t              sel;
    logic [reg_addr_width-1:0] rd_addr;
    logic [reg_addr_width-1:0] rs1_addr;
    logic [reg_addr_width-1:0] rs2_addr;
    logic [xlen-1:0]           pc;
    logic [xlen-1:0]           imm;
    logic [xlen-1:0]           rs1_value;
    logic [xlen-1:0]           rs2_value;
    logic                      commit_valid;
    logic [reg_addr_width-1:0] commit_rd;
    logic [xlen-1:0]           commit_value;
    logic                      commit_write;
    logic                      redirect_valid;
    logic [xlen-1:0]           redirect_pc;

    logic [xlen-1:0] model_mem [mem_words];
    expect_t         exp_q [$];
    expect_t         head;
    int              issued_count;
    int              commits_seen;
    int              error_count;
    int              need_commits;
    int              tests_run;
    int              test_base;
    int              test_err_base;
    logic            redir_pending;
    logic [xlen-1:0] redir_seen_pc;

    clock_gen clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    exec_subsystem exec_subsystem_i (
        .clock          (clock),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .op             (op),
        .sel            (sel),
        .rd_addr        (rd_addr),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .pc             (pc),
        .imm            (imm),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .commit_write   (commit_write),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // --------------------
    // reference model
    // --------------------
    function automatic expect_t model_exec(exec_op_t o, operand_sel_t s,
                                           logic [reg_addr_width-1:0] rd,
                                           logic [xlen-1:0] pc_v, logic [xlen-1:0] imm_v,
                                           logic [xlen-1:0] v1, logic [xlen-1:0] v2);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] addr;
        expect_t         e;
        case (s)
            sel_imm_zero: begin
                a = imm_v;
                b = '0;
            end
            sel_rs1_rs2: begin
                a = v1;
                b = v2;
            end
            sel_pc_imm: begin
                a = pc_v;
                b = imm_v;
            end
            default: begin
                a = v1;
                b = imm_v;
            end
        endcase
        addr     = a + b;
        e.rd     = rd;
        e.value  = '0;
        e.write  = (rd != '0);
        e.redir  = 1'b0;
        e.target = pc_v + imm_v;
        case (o)
            op_add: e.value = a + b;
            op_sub: e.value = a - b;
            op_and: e.value = a & b;
            op_or: e.value = a | b;
            op_xor: e.value = a ^ b;
            op_sll: e.value = a << b[4:0];
            op_srl: e.value = a >> b[4:0];
            op_sra: e.value = $signed(a) >>> b[4:0];
            op_slt: e.value = {{(xlen - 1){1'b0}}, $signed(a) < $signed(b)};
            op_sltu: e.value = {{(xlen - 1){1'b0}}, a < b};
            op_lw: e.value = model_mem[addr[7:2]];
            op_sw: begin
                model_mem[addr[7:2]] = v2;
                e.write = 1'b0;
            end
            op_jal: begin
                e.value = pc_v + 32'd4;
                e.redir = 1'b1;
            end
            op_beq: begin
                e.write = 1'b0;
                e.redir = (a == b);
            end
            default: begin
                e.write = 1'b0;
                e.redir = (a != b);
            end
        endcase
        return e;
    endfunction

    function automatic logic [reg_addr_width-1:0] pick_reg(input int lo, input int hi);
        return reg_addr_width'($urandom_range(hi, lo));
    endfunction

    // --------------------
    // issue side
    // --------------------
    task automatic send_instr(input exec_op_t o, input operand_sel_t s,
                              input logic [reg_addr_width-1:0] rd,
                              input logic [reg_addr_width-1:0] r1,
                              input logic [reg_addr_width-1:0] r2,
                              input logic [xlen-1:0] pc_v, input logic [xlen-1:0] imm_v,
                              input logic [xlen-1:0] v1, input logic [xlen-1:0] v2);
        logic accepted;
        accepted = 1'b0;
        @(negedge clock);
        issue_valid = 1'b1;
        op          = o;
        sel         = s;
        rd_addr     = rd;
        rs1_addr    = r1;
        rs2_addr    = r2;
        pc          = pc_v;
        imm         = imm_v;
        rs1_value   = v1;
        rs2_value   = v2;
        // transfer happens on the edge where ready is seen high
        while (!accepted) begin
            @(posedge clock);
            accepted = issue_ready;
        end
        issued_count++;
        exp_q.push_back(model_exec(o, s, rd, pc_v, imm_v, v1, v2));
        if (commits_seen < need_commits) begin
            $display("dependent instruction issued at time %0t before its load committed",
                     $time);
            error_count++;
        end
        if (issued_count - commits_seen > 2) begin
            $display("more than two instructions in flight at time %0t", $time);
            error_count++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        @(negedge clock);
        issue_valid = 1'b0;
        while (commits_seen < issued_count) begin
            @(negedge clock);
        end
        tests_run++;
        $display("test %0d %s finished: %0d instructions, %0d errors", num, name,
                 issued_count - test_base, error_count - test_err_base);
        test_base     = issued_count;
        test_err_base = error_count;
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic random_alu_ops();
        for (int i = 0; i < alu_count; i++) begin
            send_instr(exec_op_t'($urandom_range(9, 0)), operand_sel_t'($urandom_range(3, 0)),
                       pick_reg(0, 31), pick_reg(1, 31), pick_reg(1, 31),
                       $urandom & ~32'd3, $urandom, $urandom, $urandom);
        end
        finish_test(1, "alu ops");
    endtask

    task automatic jal_and_branches();
        logic [xlen-1:0] v1;
        logic [xlen-1:0] v2;
        logic [xlen-1:0] pc_v;
        int              kind;
        for (int i = 0; i < branch_count; i++) begin
            kind = $urandom_range(2, 0);
            pc_v = $urandom & ~32'd3;
            v1   = $urandom;
            // half the compares see equal operands
            v2   = ($urandom_range(1, 0) == 1) ? v1 : $urandom;
            if (kind == 0) begin
                send_instr(op_jal, sel_pc_imm, pick_reg(1, 31), '0, '0, pc_v,
                           $urandom & ~32'd1, v1, v2);
            end else begin
                send_instr((kind == 1) ? op_beq : op_bne, sel_rs1_rs2, '0,
                           pick_reg(1, 31), pick_reg(1, 31), pc_v, $urandom & ~32'd1, v1, v2);
            end
        end
        finish_test(2, "jal and branches");
    endtask

    task automatic store_then_load();
        logic [xlen-1:0] addr_a;
        logic [xlen-1:0] addr_b;
        logic [xlen-1:0] offset;
        for (int i = 0; i < mem_rounds; i++) begin
            addr_a = 32'($urandom_range(63, 0)) << 2;
            addr_b = ((addr_a + (32'($urandom_range(62, 0)) + 32'd1) * 4) & 32'hff);
            offset = 32'($urandom_range(7, 0)) << 2;
            send_instr(op_sw, sel_rs1_imm, '0, pick_reg(1, 31), pick_reg(1, 31),
                       32'h100, offset, addr_a - offset, $urandom);
            send_instr(op_lw, sel_rs1_imm, pick_reg(1, 31), pick_reg(1, 31), '0,
                       32'h104, offset, addr_a - offset, '0);
            send_instr(op_lw, sel_rs1_imm, pick_reg(1, 31), pick_reg(1, 31), '0,
                       32'h108, '0, addr_b, '0);
        end
        finish_test(3, "store and load");
    endtask

    task automatic load_use_stall();
        logic [xlen-1:0]           addr;
        logic [xlen-1:0]           data;
        logic [reg_addr_width-1:0] load_rd;
        for (int i = 0; i < dep_rounds; i++) begin
            addr    = 32'($urandom_range(63, 0)) << 2;
            data    = $urandom;
            load_rd = pick_reg(1, 15);
            send_instr(op_sw, sel_rs1_imm, '0, pick_reg(16, 31), pick_reg(16, 31),
                       32'h200, '0, addr, data);
            send_instr(op_lw, sel_rs1_imm, load_rd, pick_reg(16, 31), '0,
                       32'h204, '0, addr, '0);
            // dependent add may only go once the load has committed
            need_commits = issued_count;
            send_instr(op_add, sel_rs1_rs2, pick_reg(16, 31), load_rd, pick_reg(16, 31),
                       32'h208, '0, data, $urandom);
            need_commits = 0;
        end
        finish_test(4, "load use");
    endtask

    task automatic alu_burst();
        send_instr(op_lw, sel_rs1_imm, 5'd31, 5'd1, '0, 32'h300, '0,
                   32'($urandom_range(63, 0)) << 2, '0);
        for (int i = 0; i < burst_count; i++) begin
            send_instr(exec_op_t'($urandom_range(9, 0)), operand_sel_t'($urandom_range(3, 0)),
                       pick_reg(1, 30), pick_reg(1, 30), pick_reg(1, 30),
                       32'h304 + 32'(i) * 4, $urandom, $urandom, $urandom);
        end
        finish_test(5, "alu burst");
    endtask

    // --------------------
    // commit and redirect checker
    // --------------------
    task automatic check_commit(input expect_t e);
        if (commit_rd !== e.rd) begin
            $display("ERROR %0t: commit_rd %0d, expected %0d", $time, commit_rd, e.rd);
            error_count++;
        end
        if (commit_write !== e.write) begin
            $display("ERROR %0t: commit_write %b, expected %b", $time, commit_write, e.write);
            error_count++;
        end
        if (e.write && (commit_value !== e.value)) begin
            $display("ERROR %0t: commit_value %h, expected %h", $time, commit_value, e.value);
            error_count++;
        end
        if (e.redir && !redir_pending) begin
            $display("missing redirect pulse for the instruction committed at time %0t", $time);
            error_count++;
        end
        if (e.redir && redir_pending && (redir_seen_pc !== e.target)) begin
            $display("ERROR %0t: redirect_pc %h, expected %h", $time, redir_seen_pc, e.target);
            error_count++;
        end
        if (!e.redir && redir_pending) begin
            $display("unexpected redirect pulse before the commit at time %0t", $time);
            error_count++;
        end
    endtask

    // outputs settle after the rising edge, so look on the falling one
    always @(negedge clock) begin
        if (!reset) begin
            if (redirect_valid) begin
                if (redir_pending) begin
                    $display("second redirect pulse at time %0t with no commit between", $time);
                    error_count++;
                end
                redir_pending = 1'b1;
                redir_seen_pc = redirect_pc;
            end
            if (commit_valid) begin
                commits_seen++;
                if (exp_q.size() == 0) begin
                    $display("extra commit pulse at time %0t with nothing outstanding", $time);
                    error_count++;
                end else begin
                    head = exp_q.pop_front();
                    check_commit(head);
                end
                redir_pending = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clock);
        $display("timeout: run still going after %0d cycles", timeout_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin : stimulus
        issue_valid   = 1'b0;
        op            = op_add;
        sel           = sel_imm_zero;
        rd_addr       = '0;
        rs1_addr      = '0;
        rs2_addr      = '0;
        pc            = '0;
        imm           = '0;
        rs1_value     = '0;
        rs2_value     = '0;
        issued_count  = 0;
        commits_seen  = 0;
        error_count   = 0;
        need_commits  = 0;
        tests_run     = 0;
        test_base     = 0;
        test_err_base = 0;
        redir_pending = 1'b0;
        redir_seen_pc = '0;
        void'($urandom(32'h62d5));
        for (int i = 0; i < mem_words; i++) begin
            model_mem[i] = '0;
        end
        @(negedge clock);
        while (reset) begin
            @(negedge clock);
        end
        random_alu_ops();
        jal_and_branches();
        store_then_load();
        load_use_stall();
        alu_burst();
        // a few idle cycles to catch stray pulses
        repeat (20) @(negedge clock);
        if (exp_q.size() != 0) begin
            $display("%0d instructions never committed", exp_q.size());
            error_count++;
        end
        if (redir_pending) begin
            $display("redirect pulse left over with no instruction committing after it");
            error_count++;
        end
        error_count += exec_subsystem_i.exec_unit_i.exec_subsystem_props_i.failures;
        $display("summary: %0d tests, %0d instructions, %0d commits, %0d errors",
                 tests_run, issued_count, commits_seen, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
